/* src/l1Cache_macros.svh */
`ifndef L1_CACHE_MACROS_SVH
`define L1_CACHE_MACROS_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

// Associativity
`define CACHE_WAYS 4

// Lines per way
`define CACHE_SETS 16

// Line size in bytes
`define CACHE_LINE_BYTES 16

// CPU word width
`define CACHE_WORD_BITS 32

// Byte address width on both ports
`define CACHE_ADR_BITS 16

`endif

/* src/cachePkg.sv */
`include "l1Cache_macros.svh"

package cachePkg;

  // Address split is tag | set | byte offset
  localparam int offsetBits = $clog2(`CACHE_LINE_BYTES);
  localparam int setBits = $clog2(`CACHE_SETS);
  localparam int tagBits = `CACHE_ADR_BITS - setBits - offsetBits;

  // Word layout inside a line
  localparam int wordBytes = `CACHE_WORD_BITS / 8;
  localparam int byteSelBits = $clog2(wordBytes);
  localparam int wordsPerLine = `CACHE_LINE_BYTES / wordBytes;
  localparam int wordSelBits = $clog2(wordsPerLine);

  // Byte address, CPU and bus side
  typedef logic [`CACHE_ADR_BITS-1:0] adrT;

  // Set index and tag
  typedef logic [setBits-1:0] setIdxT;
  typedef logic [tagBits-1:0] tagT;

  // Payloads
  typedef logic [`CACHE_LINE_BYTES*8-1:0] lineT;
  typedef logic [`CACHE_WORD_BITS-1:0] wordT;
  typedef logic [wordBytes-1:0] byteMaskT;

  // One bit per way
  typedef logic [`CACHE_WAYS-1:0] wayMaskT;

  // Bus operation, held until acknowledged
  typedef enum logic [1:0] {
    busIdle,
    busRead,
    busWrite
  } busOpT;

endpackage

/* src/lineStore.sv */
`timescale 1ns/100ps

module lineStore import cachePkg::*; #(
  parameter type entryT = logic,
  parameter int DEPTH = 16
) (
  input  logic   clk,
  input  logic   en,
  input  logic   write,
  input  setIdxT addr,
  input  entryT  writeEntry,
  output entryT  readEntry
);

  // Storage, one entry per set
  entryT mem [DEPTH];

  ////////////////////////////////////////
  // Single port access
  ////////////////////////////////////////

  // Write cycles leave the read register alone
  // Output holds the last read while en is low
  always_ff @(posedge clk) begin
    if (en) begin
      if (write) begin
        mem[addr] <= writeEntry;
      end else begin
        readEntry <= mem[addr];
      end
    end
  end

endmodule

/* src/cacheWay.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module cacheWay import cachePkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  logic   arrayEn,
  input  setIdxT arraySet,
  input  tagT    lookupTag,
  input  lineT   writeLine,
  input  tagT    writeTag,
  input  logic   wayWrite,
  input  logic   setValid,
  input  logic   setDirty,
  input  logic   clearDirty,
  input  logic   flushSel,
  input  logic   invalidateAll,
  output logic   hit,
  output lineT   hitLine,
  output tagT    victimTag,
  output logic   victimDirty
);

  // State bits per set
  logic [`CACHE_SETS-1:0] valid;
  logic [`CACHE_SETS-1:0] dirty;

  // Set whose entries sit in the store outputs
  setIdxT readSet;
  tagT storedTag;
  lineT storedLine;

  ////////////////////////////////////////
  // Tag and data arrays
  ////////////////////////////////////////

  lineStore #(.entryT(tagT), .DEPTH(`CACHE_SETS)) tagStore_i (
    .clk(clk),
    .en(arrayEn),
    .write(wayWrite),
    .addr(arraySet),
    .writeEntry(writeTag),
    .readEntry(storedTag)
  );

  lineStore #(.entryT(lineT), .DEPTH(`CACHE_SETS)) dataStore_i (
    .clk(clk),
    .en(arrayEn),
    .write(wayWrite),
    .addr(arraySet),
    .writeEntry(writeLine),
    .readEntry(storedLine)
  );

  // Tracks the set of the last array access
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readSet <= '0;
    end else if (arrayEn) begin
      readSet <= arraySet;
    end
  end

  ////////////////////////////////////////
  // Valid and dirty flops
  ////////////////////////////////////////

  // Invalidate drops every line at once
  // Set beats clear when both are asked for
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      valid <= '0;
      dirty <= '0;
    end else if (invalidateAll) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (setValid) begin
        valid[arraySet] <= 1'b1;
      end
      if (setDirty) begin
        dirty[arraySet] <= 1'b1;
      end else if (clearDirty) begin
        dirty[arraySet] <= 1'b0;
      end
    end
  end

  // Tag compare against the latched request
  assign hit = valid[readSet] && (storedTag == lookupTag);

  // AND half of the way mux
  // Only the selected way drives nonzero values
  assign hitLine = flushSel ? storedLine : '0;
  assign victimTag = flushSel ? storedTag : '0;
  assign victimDirty = flushSel & valid[readSet] & dirty[readSet];

endmodule

/* src/wayMerge.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module wayMerge import cachePkg::*; (
  input  wayMaskT                hitWays,
  input  lineT                   hitLines [`CACHE_WAYS],
  input  tagT                    victimTags [`CACHE_WAYS],
  input  wayMaskT                victimDirtyWays,
  input  logic [wordSelBits-1:0] wordSel,
  output logic                   cacheHit,
  output lineT                   mergedLine,
  output wordT                   mergedWord,
  output tagT                    mergedVictimTag,
  output logic                   mergedVictimDirty
);

  ////////////////////////////////////////
  // OR half of the way mux
  ////////////////////////////////////////

  // Unselected ways present zero so a plain OR selects
  always_comb begin
    mergedLine = '0;
    mergedVictimTag = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      mergedLine = mergedLine | hitLines[w];
      mergedVictimTag = mergedVictimTag | victimTags[w];
    end
  end

  // Any way hitting counts as a cache hit
  assign cacheHit = |hitWays;
  assign mergedVictimDirty = |victimDirtyWays;

  // Word pick for the CPU read port
  assign mergedWord = mergedLine[wordSel*$bits(wordT) +: $bits(wordT)];

endmodule

/* src/victimPicker.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module victimPicker import cachePkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    lruUpdate,
  input  setIdxT  lookupSet,
  input  wayMaskT accessWay,
  output wayMaskT victimWay
);

  // Tree bits per set
  // bit 0 is the root, bit 1 picks in ways 0/1, bit 2 in ways 2/3
  logic [2:0] treeBits [`CACHE_SETS];
  logic [2:0] curBits;
  logic [1:0] accessIdx;

  assign curBits = treeBits[lookupSet];

  // One-hot access mask to way number
  assign accessIdx = {accessWay[3] | accessWay[2], accessWay[3] | accessWay[1]};

  ////////////////////////////////////////
  // Victim decode
  ////////////////////////////////////////

  // Follow the tree from the root down
  always_comb begin
    victimWay = '0;
    victimWay[{curBits[0], curBits[0] ? curBits[2] : curBits[1]}] = 1'b1;
  end

  // Point the touched path away from the accessed way
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        treeBits[s] <= '0;
      end
    end else if (lruUpdate) begin
      treeBits[lookupSet][0] <= ~accessIdx[1];
      if (accessIdx[1]) begin
        treeBits[lookupSet][2] <= ~accessIdx[0];
      end else begin
        treeBits[lookupSet][1] <= ~accessIdx[0];
      end
    end
  end

endmodule

/* src/cacheCtrl.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module cacheCtrl import cachePkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  // CPU side
  input  logic                   cpuReq,
  input  logic                   cpuWrite,
  input  adrT                    cpuAdr,
  input  byteMaskT               cpuByteMask,
  input  wordT                   cpuWriteData,
  input  logic                   flushReq,
  input  logic                   invalidateReq,
  output logic                   busy,
  output logic                   done,
  // Bus side
  output busOpT                  busOp,
  output adrT                    busAdr,
  output lineT                   busWriteLine,
  input  lineT                   busReadLine,
  input  logic                   busAck,
  // From the merged way outputs
  input  logic                   cacheHit,
  input  wayMaskT                hitWays,
  input  lineT                   mergedLine,
  input  tagT                    mergedVictimTag,
  input  logic                   mergedVictimDirty,
  input  wayMaskT                victimWay,
  // To the ways
  output logic                   arrayEn,
  output setIdxT                 arraySet,
  output tagT                    lookupTag,
  output logic [wordSelBits-1:0] wordSel,
  output lineT                   writeLine,
  output tagT                    writeTag,
  output wayMaskT                writeWay,
  output wayMaskT                setValidWay,
  output wayMaskT                setDirtyWay,
  output wayMaskT                clearDirtyWay,
  output wayMaskT                flushSelWay,
  output logic                   invalidateAll,
  // To the replacement logic
  output logic                   lruUpdate,
  output setIdxT                 lookupSet
);

  typedef enum logic [2:0] {
    idle, lookup, writeBack, fill, refill, flushRead, flushWrite, invalidate
  } stateT;

  stateT state;
  stateT nextState;

  // Latched request
  adrT reqAdr;
  logic reqWrite;
  byteMaskT reqMask;
  wordT reqData;
  setIdxT reqSet;

  // Victim chosen at the miss, flush walk position
  wayMaskT selWay;
  setIdxT flushSet;
  wayMaskT flushWay;
  logic lastWay;
  logic lastSet;
  logic flushStep;
  busOpT stateOp;
  lineT baseLine;
  byteMaskT effMask;

  assign reqSet = reqAdr[offsetBits +: setBits];
  assign lookupTag = reqAdr[`CACHE_ADR_BITS-1 -: tagBits];
  assign lookupSet = reqSet;
  assign wordSel = reqAdr[byteSelBits +: wordSelBits];
  assign writeTag = lookupTag;

  ////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  // Request fields captured on acceptance
  always_ff @(posedge clk) begin
    if (state == idle && cpuReq) begin
      reqAdr <= cpuAdr;
      reqWrite <= cpuWrite;
      reqMask <= cpuByteMask;
      reqData <= cpuWriteData;
    end
  end

  // A refill goes back through lookup, which then hits
  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (cpuReq) begin
          nextState = lookup;
        end else if (flushReq) begin
          nextState = flushRead;
        end else if (invalidateReq) begin
          nextState = invalidate;
        end
      end
      lookup: begin
        if (cacheHit) begin
          nextState = idle;
        end else begin
          nextState = mergedVictimDirty ? writeBack : fill;
        end
      end
      writeBack: if (busAck) nextState = fill;
      fill: if (busAck) nextState = refill;
      refill: nextState = lookup;
      flushRead: begin
        if (mergedVictimDirty) begin
          nextState = flushWrite;
        end else if (lastWay && lastSet) begin
          nextState = idle;
        end
      end
      flushWrite: if (busAck) nextState = flushRead;
      default: nextState = idle;
    endcase
  end

  // Victim is frozen for the write-back and fill
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      selWay <= '0;
    end else if (state == lookup) begin
      selWay <= victimWay;
    end
  end

  ////////////////////////////////////////
  // Flush walk counters
  ////////////////////////////////////////

  // Clean slot moves on, dirty slot is rechecked after its write
  assign flushStep = (state == flushRead) && !mergedVictimDirty;
  assign lastWay = flushWay[`CACHE_WAYS-1];
  assign lastSet = (flushSet == setIdxT'(`CACHE_SETS-1));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flushSet <= '0;
      flushWay <= wayMaskT'(1);
    end else if (state == idle) begin
      flushSet <= '0;
      flushWay <= wayMaskT'(1);
    end else if (flushStep) begin
      flushWay <= {flushWay[`CACHE_WAYS-2:0], flushWay[`CACHE_WAYS-1]};
      if (lastWay) begin
        flushSet <= flushSet + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Array control
  ////////////////////////////////////////

  always_comb begin
    arrayEn = 1'b0;
    arraySet = reqSet;
    writeWay = '0;
    setValidWay = '0;
    setDirtyWay = '0;
    clearDirtyWay = '0;
    flushSelWay = selWay;
    case (state)
      // Read starts in the request cycle, set 0 for a flush
      idle: begin
        arrayEn = cpuReq | flushReq;
        arraySet = cpuReq ? cpuAdr[offsetBits +: setBits] : '0;
      end
      // Hit way drives the line, else the candidate victim
      lookup: begin
        flushSelWay = cacheHit ? hitWays : victimWay;
        if (cacheHit && reqWrite) begin
          arrayEn = 1'b1;
          writeWay = hitWays;
          setDirtyWay = hitWays;
        end
      end
      // Fill lands in the victim way with the store merged in
      fill: begin
        if (busAck) begin
          arrayEn = 1'b1;
          writeWay = selWay;
          setValidWay = selWay;
          setDirtyWay = reqWrite ? selWay : '0;
          clearDirtyWay = reqWrite ? '0 : selWay;
        end
      end
      refill: arrayEn = 1'b1;
      // Next set is read once its last way is clean
      flushRead: begin
        flushSelWay = flushWay;
        arraySet = flushSet + 1'b1;
        arrayEn = flushStep & lastWay;
      end
      flushWrite: begin
        flushSelWay = flushWay;
        arraySet = flushSet;
        clearDirtyWay = busAck ? flushWay : '0;
      end
      default: ;
    endcase
  end

  // Store bytes go over the hit line or the fetched line
  assign baseLine = (state == fill) ? busReadLine : mergedLine;
  assign effMask = reqWrite ? reqMask : '0;

  always_comb begin
    writeLine = baseLine;
    for (int b = 0; b < wordBytes; b++) begin
      if (effMask[b]) begin
        writeLine[wordSel*$bits(wordT) + b*8 +: 8] = reqData[b*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  always_comb begin
    case (state)
      writeBack, flushWrite: stateOp = busWrite;
      fill: stateOp = busRead;
      default: stateOp = busIdle;
    endcase
  end

  // Drops to idle for one cycle after every acknowledge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busOp <= busIdle;
    end else if (busAck) begin
      busOp <= busIdle;
    end else if (busOp == busIdle) begin
      busOp <= stateOp;
    end
  end

  // Victim tag for write-backs, request tag for fills
  assign busAdr = {(state == fill) ? lookupTag : mergedVictimTag,
                   (state == flushWrite) ? flushSet : reqSet,
                   {offsetBits{1'b0}}};
  // Arrays sit idle during a write, so the victim line holds
  assign busWriteLine = mergedLine;

  ////////////////////////////////////////
  // CPU status
  ////////////////////////////////////////

  assign busy = (state != idle);
  assign done = (state == lookup && cacheHit) || (state == invalidate) ||
                (flushStep && lastWay && lastSet);
  assign lruUpdate = (state == lookup) && cacheHit;
  assign invalidateAll = (state == invalidate);

endmodule

/* src/l1DataCache.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module l1DataCache import cachePkg::*; (
  input  logic     clk,
  input  logic     arstN,
  // CPU side
  input  logic     cpuReq,
  input  logic     cpuWrite,
  input  adrT      cpuAdr,
  input  byteMaskT cpuByteMask,
  input  wordT     cpuWriteData,
  input  logic     flushReq,
  input  logic     invalidateReq,
  output logic     busy,
  output logic     done,
  output wordT     readData,
  // Bus side
  output busOpT    busOp,
  output adrT      busAdr,
  output lineT     busWriteLine,
  input  lineT     busReadLine,
  input  logic     busAck
);

  // Controller to ways
  logic arrayEn;
  setIdxT arraySet;
  tagT lookupTag;
  logic [wordSelBits-1:0] wordSel;
  lineT writeLine;
  tagT writeTag;
  wayMaskT writeWay;
  wayMaskT setValidWay;
  wayMaskT setDirtyWay;
  wayMaskT clearDirtyWay;
  wayMaskT flushSelWay;
  logic invalidateAll;

  // Ways to merge
  wayMaskT hitWays;
  wayMaskT victimDirtyWays;
  lineT hitLines [`CACHE_WAYS];
  tagT victimTags [`CACHE_WAYS];

  // Merge and picker to controller
  logic cacheHit;
  lineT mergedLine;
  tagT mergedVictimTag;
  logic mergedVictimDirty;
  wayMaskT victimWay;
  logic lruUpdate;
  setIdxT lookupSet;

  cacheCtrl ctrl_i (
    .clk(clk), .arstN(arstN),
    .cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuAdr(cpuAdr),
    .cpuByteMask(cpuByteMask), .cpuWriteData(cpuWriteData),
    .flushReq(flushReq), .invalidateReq(invalidateReq),
    .busy(busy), .done(done),
    .busOp(busOp), .busAdr(busAdr), .busWriteLine(busWriteLine),
    .busReadLine(busReadLine), .busAck(busAck),
    .cacheHit(cacheHit), .hitWays(hitWays), .mergedLine(mergedLine),
    .mergedVictimTag(mergedVictimTag), .mergedVictimDirty(mergedVictimDirty),
    .victimWay(victimWay),
    .arrayEn(arrayEn), .arraySet(arraySet), .lookupTag(lookupTag), .wordSel(wordSel),
    .writeLine(writeLine), .writeTag(writeTag), .writeWay(writeWay),
    .setValidWay(setValidWay), .setDirtyWay(setDirtyWay),
    .clearDirtyWay(clearDirtyWay), .flushSelWay(flushSelWay),
    .invalidateAll(invalidateAll), .lruUpdate(lruUpdate), .lookupSet(lookupSet)
  );

  // Way array, one bit of each mask per copy
  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gWay
    cacheWay way_i (
      .clk(clk), .arstN(arstN),
      .arrayEn(arrayEn), .arraySet(arraySet), .lookupTag(lookupTag),
      .writeLine(writeLine), .writeTag(writeTag), .wayWrite(writeWay[w]),
      .setValid(setValidWay[w]), .setDirty(setDirtyWay[w]),
      .clearDirty(clearDirtyWay[w]), .flushSel(flushSelWay[w]),
      .invalidateAll(invalidateAll),
      .hit(hitWays[w]), .hitLine(hitLines[w]),
      .victimTag(victimTags[w]), .victimDirty(victimDirtyWays[w])
    );
  end

  wayMerge merge_i (
    .hitWays(hitWays), .hitLines(hitLines), .victimTags(victimTags),
    .victimDirtyWays(victimDirtyWays), .wordSel(wordSel),
    .cacheHit(cacheHit), .mergedLine(mergedLine), .mergedWord(readData),
    .mergedVictimTag(mergedVictimTag), .mergedVictimDirty(mergedVictimDirty)
  );

  victimPicker picker_i (
    .clk(clk), .arstN(arstN),
    .lruUpdate(lruUpdate), .lookupSet(lookupSet), .accessWay(hitWays),
    .victimWay(victimWay)
  );

endmodule

/* verif/busMemory.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module busMemory import cachePkg::*; #(
  parameter int LINES = 128
) (
  input  logic  clk,
  input  busOpT busOp,
  input  adrT   busAdr,
  input  lineT  busWriteLine,
  output lineT  busReadLine,
  output logic  busAck,
  output int    errors
);

  // Backing store, one entry per line
  lineT lines [LINES];

  int seed = 78;
  int waitLeft = -1;
  int errCount = 0;
  logic ackReg = 1'b0;
  lineT readReg = '0;

  assign busAck = ackReg;
  assign busReadLine = readReg;
  assign errors = errCount;

  // Start pattern mixes low and high address bits
  function automatic logic [7:0] fillByte(input int a);
    return 8'((a * 13) ^ (a >> 5));
  endfunction

  initial begin
    for (int l = 0; l < LINES; l++) begin
      for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
        lines[l][b*8 +: 8] = fillByte(l * `CACHE_LINE_BYTES + b);
      end
    end
  end

  ////////////////////////////////////////
  // Operation service
  ////////////////////////////////////////

  // Delay of 1 to 6 cycles, then a one cycle ack
  always @(negedge clk) begin
    int idx;
    if (ackReg) begin
      ackReg = 1'b0;
    end else if (busOp != busIdle) begin
      if (waitLeft < 0) begin
        waitLeft = 1 + ({$random(seed)} % 6);
      end
      waitLeft--;
      if (waitLeft == 0) begin
        waitLeft = -1;
        idx = int'(busAdr >> offsetBits);
        assert (busAdr[offsetBits-1:0] == '0) else begin
          $display("Bus address %h at %0t ns is not line aligned", busAdr, $time);
          errCount++;
        end
        assert (idx < LINES) else begin
          $display("Bus address %h at %0t ns is outside the memory", busAdr, $time);
          errCount++;
        end
        // Whole line moves per ack
        if (idx < LINES) begin
          if (busOp == busRead) begin
            readReg = lines[idx];
          end else begin
            lines[idx] = busWriteLine;
          end
        end
        ackReg = 1'b1;
      end
    end
  end

endmodule

/* verif/l1DataCacheTb.sv */
`timescale 1ns/100ps
`include "l1Cache_macros.svh"

module l1DataCacheTb import cachePkg::*; ();

  localparam int memLines = 128;
  localparam int memBytes = memLines * `CACHE_LINE_BYTES;

  logic clk = 1'b0;
  logic arstN;
  logic cpuReq;
  logic cpuWrite;
  adrT cpuAdr;
  byteMaskT cpuByteMask;
  wordT cpuWriteData;
  logic flushReq;
  logic invalidateReq;
  logic busy;
  logic done;
  wordT readData;
  busOpT busOp;
  adrT busAdr;
  lineT busWriteLine;
  lineT busReadLine;
  logic busAck;
  int memErrors;

  // Expected memory image, byte per address
  logic [7:0] shadow [memBytes];

  int seed = 78;
  int errors = 0;
  int checks = 0;
  int issued = 0;
  int cycles = 0;
  int wbChecks = 0;
  int hitChecks = 0;
  logic wbSeen = 1'b0;

  always #20 clk = ~clk;

  l1DataCache dut_i (
    .clk(clk), .arstN(arstN),
    .cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuAdr(cpuAdr),
    .cpuByteMask(cpuByteMask), .cpuWriteData(cpuWriteData),
    .flushReq(flushReq), .invalidateReq(invalidateReq),
    .busy(busy), .done(done), .readData(readData),
    .busOp(busOp), .busAdr(busAdr), .busWriteLine(busWriteLine),
    .busReadLine(busReadLine), .busAck(busAck)
  );

  busMemory #(.LINES(memLines)) mem_i (
    .clk(clk), .busOp(busOp), .busAdr(busAdr), .busWriteLine(busWriteLine),
    .busReadLine(busReadLine), .busAck(busAck), .errors(memErrors)
  );

  ////////////////////////////////////////
  // Shadow model
  ////////////////////////////////////////

  // Same start pattern as the bus memory
  function automatic logic [7:0] fillByte(input int a);
    return 8'((a * 13) ^ (a >> 5));
  endfunction

  // Little endian bytes within a word
  function automatic wordT shadowWord(input adrT a);
    wordT w;
    for (int b = 0; b < wordBytes; b++) begin
      w[b*8 +: 8] = shadow[a + b];
    end
    return w;
  endfunction

  function automatic lineT shadowLine(input adrT a);
    lineT l;
    adrT base;
    base = {a[`CACHE_ADR_BITS-1:offsetBits], {offsetBits{1'b0}}};
    for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
      l[b*8 +: 8] = shadow[base + b];
    end
    return l;
  endfunction

  task automatic applyWrite(input adrT a, input byteMaskT m, input wordT d);
    for (int b = 0; b < wordBytes; b++) begin
      if (m[b]) begin
        shadow[a + b] = d[b*8 +: 8];
      end
    end
  endtask

  task automatic expectEqual(input string sig, input logic [127:0] exp,
                             input logic [127:0] got);
    checks++;
    assert (exp === got) else begin
      $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, sig, exp, got);
      errors++;
    end
  endtask

  task automatic reportTest(input string name);
    $display("test %s finished, errors so far %0d", name, errors + memErrors);
  endtask

  ////////////////////////////////////////
  // CPU side drivers
  ////////////////////////////////////////

  // One request, then wait for done while watching the bus
  task automatic access(input logic w, input adrT a, input byteMaskT m, input wordT d,
                        output wordT rd, output int lat, output logic busUsed,
                        output adrT fillAdr);
    @(negedge clk);
    cpuReq = 1'b1;
    cpuWrite = w;
    cpuAdr = a;
    cpuByteMask = m;
    cpuWriteData = d;
    issued++;
    lat = 0;
    busUsed = 1'b0;
    fillAdr = '1;
    do begin
      @(negedge clk);
      cpuReq = 1'b0;
      lat++;
      if (busOp != busIdle) begin
        busUsed = 1'b1;
      end
      if (busOp == busRead) begin
        fillAdr = busAdr;
      end
    end while (!done);
    rd = readData;
  endtask

  // Flush when doFlush is set, invalidate otherwise
  task automatic runCommand(input logic doFlush, output int lat);
    @(negedge clk);
    flushReq = doFlush;
    invalidateReq = !doFlush;
    issued++;
    lat = 0;
    do begin
      @(negedge clk);
      flushReq = 1'b0;
      invalidateReq = 1'b0;
      lat++;
    end while (!done);
  endtask

  // Each write-back is compared once with the shadow line
  always @(negedge clk) begin
    if (busOp == busWrite && !wbSeen) begin
      wbSeen = 1'b1;
      wbChecks++;
      expectEqual("busAdr offset", '0, busAdr[offsetBits-1:0]);
      expectEqual("busWriteLine", shadowLine(busAdr), busWriteLine);
    end else if (busOp == busIdle) begin
      wbSeen = 1'b0;
    end
  end

  // Run limit grows with the requests issued
  always @(posedge clk) begin
    cycles++;
    if (cycles > 200 * issued + 5000) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    wordT rd;
    int lat;
    logic busUsed;
    adrT fillAdr;
    adrT a;
    adrT prevAdr;
    logic w;
    logic sameLine;

    arstN = 1'b0;
    cpuReq = 1'b0;
    cpuWrite = 1'b0;
    cpuAdr = '0;
    cpuByteMask = '0;
    cpuWriteData = '0;
    flushReq = 1'b0;
    invalidateReq = 1'b0;
    prevAdr = '0;
    for (int i = 0; i < memBytes; i++) begin
      shadow[i] = fillByte(i);
    end
    repeat (10) @(negedge clk);
    arstN = 1'b1;

    // Quiet outputs before the first request
    repeat (5) begin
      @(negedge clk);
      expectEqual("busy", 0, busy);
      expectEqual("done", 0, done);
      expectEqual("busOp", busIdle, busOp);
    end
    reportTest("reset idle");

    // Random traffic in the low 2 KB, every fourth access reuses the last line
    for (int n = 0; n < 400; n++) begin
      if (n > 0 && ($random(seed) & 3) == 0) begin
        a = {prevAdr[`CACHE_ADR_BITS-1:offsetBits], 2'($random(seed)), 2'b00};
      end else begin
        a = adrT'($random(seed)) & adrT'(memBytes - wordBytes);
      end
      w = 1'($random(seed));
      sameLine = (n > 0) && (a[`CACHE_ADR_BITS-1:offsetBits] ==
                             prevAdr[`CACHE_ADR_BITS-1:offsetBits]);
      if (w) begin
        cpuByteMask = byteMaskT'($random(seed));
        cpuWriteData = $random(seed);
        applyWrite(a, cpuByteMask, cpuWriteData);
      end
      access(w, a, cpuByteMask, cpuWriteData, rd, lat, busUsed, fillAdr);
      if (!w) begin
        expectEqual("readData", shadowWord(a), rd);
      end
      if (!w && sameLine) begin
        hitChecks++;
        expectEqual("hit latency", 1, lat);
        assert (!busUsed) else begin
          $display("Read of a resident line at %0t ns started a bus operation", $time);
          errors++;
        end
      end
      prevAdr = a;
    end
    reportTest("random reads and writes");
    $display("test resident line hits checked %0d reads", hitChecks);

    runCommand(1'b1, lat);
    $display("test write-backs checked %0d bus writes", wbChecks);

    // Memory must hold every dirty byte after the flush
    for (int l = 0; l < memLines; l++) begin
      expectEqual($sformatf("memory line %0d", l),
                  shadowLine(adrT'(l * `CACHE_LINE_BYTES)), mem_i.lines[l]);
    end
    reportTest("flush");

    // Bring eight clean lines in, drop them, read them again
    for (int k = 0; k < 8; k++) begin
      access(1'b0, adrT'(k * 'h110), '0, '0, rd, lat, busUsed, fillAdr);
    end
    runCommand(1'b0, lat);
    expectEqual("invalidate latency", 1, lat);
    for (int k = 0; k < 8; k++) begin
      a = adrT'(k * 'h110 + 4 * (k % 4));
      access(1'b0, a, '0, '0, rd, lat, busUsed, fillAdr);
      expectEqual("fill busAdr", adrT'(k * 'h110), fillAdr);
      expectEqual("readData", shadowWord(a), rd);
    end
    reportTest("invalidate");

    $display("checks %0d, errors %0d", checks, errors + memErrors);
    if (errors + memErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* l1DataCache.f */
+incdir+src
src/cachePkg.sv
src/lineStore.sv
src/cacheWay.sv
src/wayMerge.sv
src/victimPicker.sv
src/cacheCtrl.sv
src/l1DataCache.sv
verif/busMemory.sv
verif/l1DataCacheTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
  --top-module l1DataCacheTb \
  -f l1DataCache.f

# Run output goes to a log that decides the result
./obj_dir/Vl1DataCacheTb > sim.log
cat sim.log

if grep -qx "TEST OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
